/* Bender.yml */
package:
  name: softmax

sources:
  - logic/softmax_pkg.sv
  - logic/softmax_serial_div.sv
  - logic/softmax_row_stats.sv
  - logic/softmax_div_dispatch.sv
  - logic/softmax_row_buffers.sv
  - logic/softmax_stream.sv
  - logic/softmax_top.sv
  - target: test
    files:
      - bench/softmax_checker.sv
      - bench/softmax_tb.sv

/* bench/softmax_checker.sv */
// ################################################
// Softmax checker
// Compares stream rows and counts done pulses
// ################################################

`timescale 1ns/1ns

module softmax_checker #(
  parameter int unsigned M = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [M-1:0][7:0] stream_i,
  input  logic             valid_i,
  input  logic             done_i,
  input  logic             exp_push_i,
  input  logic [M-1:0][7:0] exp_i,
  output int               errors_o,
  output int               tests_o,
  output int               done_count_o
);

  logic [M*8-1:0] exp_q [$];
  int errors;
  int tests;
  int done_count;

  assign errors_o     = errors;
  assign tests_o      = tests;
  assign done_count_o = done_count;

  task automatic compare_row(input logic [M*8-1:0] expected);
    int bad;
    bad = 0;
    for (int i = 0; i < M; i++) begin
      if (stream_i[i] !== expected[i*8 +: 8]) begin
        $display("** Error stream_o[%0d]: expected 0x%02h, got 0x%02h",
                 i, expected[i*8 +: 8], stream_i[i]);
        bad++;
      end
    end
    errors = errors + bad;
    tests  = tests + 1;
    $display("stream request %0d: %s", tests, (bad == 0) ? "pass" : "FAIL");
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      errors     = 0;
      tests      = 0;
      done_count = 0;
      exp_q.delete();
    end else begin
      if (exp_push_i) begin
        exp_q.push_back(exp_i);
      end
      if (done_i) begin
        done_count = done_count + 1;
      end
      if (valid_i) begin
        if (exp_q.size() == 0) begin
          $display("stream_valid_o went high with no pending request");
          errors = errors + 1;
        end else begin
          compare_row(exp_q.pop_front());
        end
      end
    end
  end

endmodule

/* bench/softmax_tb.sv */
// ################################################
// Softmax testbench
// Replays the trace file against the softmax unit
// ################################################

`timescale 1ns/1ns

module softmax_tb;
  import softmax_pkg::*;

  localparam int unsigned M = 8;
  localparam int unsigned N = 4;
  localparam string TracePath = "bench/softmax_trace.txt";

  logic clk = 1'b0;
  logic rst_n;
  ctrl_t ctrl;
  step_e step;
  logic calc_en;
  score_t [N-1:0] beat_scores;
  logic [N-1:0] beat_mask;
  logic stream_en;
  score_t [M-1:0] stream_scores;
  cnt_t inner_tile;
  cnt_t tile_y;
  logic [M-1:0][WI-1:0] stream_out;
  logic stream_valid;
  logic done;
  logic exp_push;
  logic [M-1:0][7:0] exp_vec;
  int errors, tests, done_count;

  int fd, code, n_lines, n_streams, tb_errors, gap, mask_v;
  int cycles = 0;
  int cycle_limit = 0;
  int seed = 59;
  int vals [M];
  int ex [M];
  int a, b;
  string tag, line;
  logic idle_bad;
  logic early_done;

  always #2 clk = ~clk;

  softmax_top #(
    .M            (M),
    .N            (N),
    .NumDiv       (2),
    .SoftmaxShift (2)
  ) DUT (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .ctrl_i              (ctrl),
    .step_i              (step),
    .calc_en_i           (calc_en),
    .beat_scores_i       (beat_scores),
    .beat_mask_i         (beat_mask),
    .stream_en_i         (stream_en),
    .stream_scores_i     (stream_scores),
    .stream_inner_tile_i (inner_tile),
    .stream_tile_y_i     (tile_y),
    .stream_o            (stream_out),
    .stream_valid_o      (stream_valid),
    .softmax_done_o      (done)
  );

  softmax_checker #(
    .M (M)
  ) u_checker (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .stream_i     (stream_out),
    .valid_i      (stream_valid),
    .done_i       (done),
    .exp_push_i   (exp_push),
    .exp_i        (exp_vec),
    .errors_o     (errors),
    .tests_o      (tests),
    .done_count_o (done_count)
  );

  // Run limit grows with the trace length plus room for division
  always @(posedge clk) begin
    cycles++;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles", cycles);
      $display("test failed");
      $finish;
    end
  end

  initial begin
    rst_n = 1'b0;
    ctrl = '0;
    step = StepIdle;
    calc_en = 1'b0;
    beat_scores = '0;
    beat_mask = '0;
    stream_en = 1'b0;
    stream_scores = '0;
    inner_tile = '0;
    tile_y = '0;
    exp_push = 1'b0;
    exp_vec = '0;
    n_lines = 0;
    n_streams = 0;
    tb_errors = 0;
    idle_bad = 1'b0;
    early_done = 1'b0;

    fd = $fopen(TracePath, "r");
    if (fd == 0) begin
      $display("could not open the trace file");
      $display("test failed");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) != 0) begin
          n_lines++;
        end
      end
      $fclose(fd);
      cycle_limit = n_lines * 3 + M * 20 + 100;

      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      repeat (4) begin
        @(negedge clk);
        if (stream_valid || done) begin
          idle_bad = 1'b1;
        end
      end
      if (idle_bad) begin
        $display("stream_valid_o or softmax_done_o active while idle after reset");
        tb_errors++;
      end
      $display("idle after reset: %s", idle_bad ? "FAIL" : "pass");

      fd = $fopen(TracePath, "r");
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", tag);
        if (code != 1) begin
          break;
        end
        case (tag)
          "#": code = $fgets(line, fd);
          "C": begin
            code = $fscanf(fd, "%d %d", a, b);
            @(posedge clk);
            ctrl <= '{seq_length: cnt_t'(a), tile_s: cnt_t'(b)};
            step <= StepQk;
          end
          "B": begin
            for (int i = 0; i < N; i++) begin
              code = $fscanf(fd, "%d", vals[i]);
            end
            code = $fscanf(fd, "%h", mask_v);
            @(posedge clk);
            calc_en <= 1'b1;
            for (int i = 0; i < N; i++) begin
              beat_scores[i] <= score_t'(vals[i]);
            end
            beat_mask <= N'(mask_v);
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) begin
              @(posedge clk);
              calc_en <= 1'b0;
            end
          end
          "W": begin
            @(posedge clk);
            calc_en <= 1'b0;
            step <= StepIdle;
            @(negedge clk);
            early_done = (done_count != 0);
            if (early_done) begin
              $display("softmax_done_o pulsed before the last beat");
              tb_errors++;
            end
            while (done_count == 0) @(negedge clk);
            $display("division done: %s", early_done ? "FAIL" : "pass");
          end
          "S": begin
            for (int i = 0; i < M; i++) begin
              code = $fscanf(fd, "%d", vals[i]);
            end
            code = $fscanf(fd, "%d %d", a, b);
            for (int i = 0; i < M; i++) begin
              code = $fscanf(fd, "%d", ex[i]);
            end
            @(posedge clk);
            stream_en <= 1'b1;
            exp_push <= 1'b1;
            inner_tile <= cnt_t'(a);
            tile_y <= cnt_t'(b);
            for (int i = 0; i < M; i++) begin
              stream_scores[i] <= score_t'(vals[i]);
              exp_vec[i] <= 8'(ex[i]);
            end
            @(posedge clk);
            stream_en <= 1'b0;
            exp_push <= 1'b0;
            n_streams++;
          end
          default: begin
            $display("unknown trace tag %s", tag);
            tb_errors++;
          end
        endcase
      end
      $fclose(fd);

      while (tests < n_streams) @(negedge clk);
      @(negedge clk);
      if (done_count != 1) begin
        $display("expected one softmax_done_o pulse, saw %0d", done_count);
        tb_errors++;
      end
      $display("done pulse count: %s", (done_count == 1) ? "pass" : "FAIL");
      $display("%0d stream checks, %0d done pulses, %0d errors",
               tests, done_count, errors + tb_errors);
      if (errors + tb_errors == 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
      $finish;
    end
  end

endmodule

/* bench/softmax_trace.txt */
# C seq_length tile_s | B s0 s1 s2 s3 mask(hex) | W waits for the division done pulse
# S s0..s7 inner_tile tile_y e0..e7 (expected stream outputs)
C 13 2
B 0 0 0 0 0
B 0 0 0 0 f
B 4 3 2 1 0
B 0 0 0 0 0
B 0 0 0 0 0
B 0 0 0 0 0
B 0 0 0 0 0
B 0 0 0 0 0
B 0 0 0 0 0
B 0 0 0 0 f
B 0 0 0 0 0
B 8 0 0 0 2
B 0 0 0 0 0
B 0 0 0 0 0
B 0 0 0 0 0
B 0 0 0 0 0
B 0 0 0 0 0
B 0 0 0 0 f
B 0 0 0 0 0
B 100 100 100 100 f
B 0 0 0 0 0
B 0 0 0 0 0
B 0 0 0 0 0
B 0 0 0 0 0
B 0 0 0 0 0
B 0 0 0 0 f
B 0 0 0 0 0
B 8 100 100 100 0
B 0 0 0 0 0
B 0 0 0 0 0
B 0 0 0 0 0
B 0 0 0 0 0
W
S 0 0 0 0 0 0 0 0 0 0 19 19 19 19 19 19 19 19
S -128 -128 -128 -128 -128 -128 -128 -128 0 0 255 255 255 255 255 255 255 255
S 4 3 2 1 0 -1 -4 -8 0 0 34 34 17 17 17 17 8 4
S 8 8 4 0 -8 8 8 8 1 0 73 73 36 18 4 0 0 0
S 0 0 0 0 0 0 0 0 1 0 19 19 19 19 19 0 0 0
S 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0
S 0 0 0 0 0 0 0 0 0 0 19 19 19 19 19 19 19 19
S 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0

/* logic/softmax_div_dispatch.sv */
// ################################################
// Softmax division dispatch
// Sum FIFO feeding serial dividers round-robin
// ################################################

`timescale 1ns/1ns

module softmax_div_dispatch #(
  parameter int unsigned M      = softmax_pkg::DefM,
  parameter int unsigned NumDiv = softmax_pkg::DefNumDiv
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 push_i,
  input  softmax_pkg::acc_t    push_data_i,
  output softmax_pkg::buf_wr_t sum_wr_o,
  output logic                 done_o
);
  import softmax_pkg::*;

  localparam int unsigned FifoAw = (M > 1) ? $clog2(M) : 1;
  localparam int unsigned PtrW   = (NumDiv > 1) ? $clog2(NumDiv) : 1;

  acc_t              fifo_mem [M];
  acc_t              fifo_head;
  logic [FifoAw-1:0] head_q, tail_q;
  logic [FifoAw:0]   used_q;
  logic              fifo_full, fifo_empty, pop, collect;
  logic [PtrW-1:0]   rd_ptr_q, wr_ptr_q;
  cnt_t              wr_addr_q;

  logic [NumDiv-1:0] div_valid_in, div_ready_in, div_valid_out, div_ready_out;
  acc_t [NumDiv-1:0] div_quot;

  assign fifo_head  = fifo_mem[head_q];
  assign fifo_full  = (used_q == M);
  assign fifo_empty = (used_q == '0);
  assign pop        = !fifo_empty && div_ready_out[rd_ptr_q];
  assign collect    = div_valid_out[wr_ptr_q];

  // Issue and collection both follow the round-robin order
  always_comb begin
    div_valid_in           = '0;
    div_ready_in           = '0;
    div_valid_in[rd_ptr_q] = !fifo_empty;
    div_ready_in[wr_ptr_q] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q    <= '0;
      tail_q    <= '0;
      used_q    <= '0;
      rd_ptr_q  <= '0;
      wr_ptr_q  <= '0;
      wr_addr_q <= '0;
    end else begin
      used_q <= used_q + push_i - pop;
      if (push_i) begin
        tail_q <= (tail_q == FifoAw'(M - 1)) ? '0 : tail_q + 1'b1;
      end
      if (pop) begin
        head_q   <= (head_q == FifoAw'(M - 1)) ? '0 : head_q + 1'b1;
        rd_ptr_q <= (rd_ptr_q == PtrW'(NumDiv - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (collect) begin
        wr_ptr_q  <= (wr_ptr_q == PtrW'(NumDiv - 1)) ? '0 : wr_ptr_q + 1'b1;
        wr_addr_q <= done_o ? '0 : wr_addr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      fifo_mem[tail_q] <= push_data_i;
    end
  end

  for (genvar k = 0; k < NumDiv; k++) begin : g_div
    softmax_serial_div u_div (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .valid_i    (div_valid_in[k]),
      .divisor_i  (fifo_head),
      .ready_i    (div_ready_in[k]),
      .ready_o    (div_ready_out[k]),
      .valid_o    (div_valid_out[k]),
      .quotient_o (div_quot[k])
    );
  end

  assign sum_wr_o = '{en: collect, addr: wr_addr_q, data: div_quot[wr_ptr_q]};
  // Last reciprocal of the pass
  assign done_o   = collect && (wr_addr_q == cnt_t'(M - 1));

  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !fifo_full);

endmodule

/* logic/softmax_pkg.sv */
// ################################################
// Softmax package
// Default parameters, types and shared shift helper
// ################################################

package softmax_pkg;

  // Defaults for the top-level parameters
  localparam int unsigned DefM            = 8;
  localparam int unsigned DefN            = 4;
  localparam int unsigned DefNumDiv       = 2;
  localparam int unsigned DefSoftmaxShift = 2;

  localparam int unsigned WI            = 8;
  localparam int unsigned AccWidth      = 16;
  localparam int unsigned CntWidth      = 8;
  localparam int unsigned ReciprocalNum = 65535;
  localparam int unsigned ExpOne        = 256;

  typedef logic signed [WI-1:0] score_t;
  typedef logic [AccWidth-1:0]  acc_t;
  typedef logic [CntWidth-1:0]  cnt_t;

  typedef enum logic [1:0] {
    StepIdle,
    StepQk,
    StepAv
  } step_e;

  typedef enum logic [1:0] {
    DivIdle,
    DivBusy,
    DivDone
  } div_state_e;

  typedef struct packed {
    cnt_t seq_length;
    cnt_t tile_s;
  } ctrl_t;

  typedef struct packed {
    logic en;
    cnt_t addr;
  } buf_rd_t;

  typedef struct packed {
    logic en;
    cnt_t addr;
    acc_t data;
  } buf_wr_t;

  // Right shift, rounded up when the highest dropped bit is set
  function automatic logic [WI-1:0] round_shift(logic [WI-1:0] diff, int unsigned sh);
    logic [WI:0] ext;
    ext = {diff, 1'b0} >> sh;
    return ext[WI:1] + WI'(ext[0]);
  endfunction

endpackage

/* logic/softmax_row_buffers.sv */
// ################################################
// Softmax row buffers
// Per-row max and sum or reciprocal storage
// ################################################

`timescale 1ns/1ns

module softmax_row_buffers #(
  parameter int unsigned M = softmax_pkg::DefM
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  softmax_pkg::buf_rd_t max_rd_i,
  input  softmax_pkg::buf_wr_t max_wr_i,
  input  softmax_pkg::buf_rd_t sum_rd_i,
  input  softmax_pkg::buf_rd_t stream_rd_i,
  input  softmax_pkg::buf_wr_t stat_sum_wr_i,
  input  softmax_pkg::buf_wr_t div_sum_wr_i,
  output softmax_pkg::score_t  max_rd_data_o,
  output softmax_pkg::acc_t    sum_rd_data_o,
  output softmax_pkg::score_t  stream_max_o,
  output softmax_pkg::acc_t    stream_sum_o
);
  import softmax_pkg::*;

  localparam int unsigned AddrW = (M > 1) ? $clog2(M) : 1;

  score_t  max_mem [M];
  acc_t    sum_mem [M];
  buf_wr_t sum_wr;

  // Pipeline sums and divider reciprocals share one write port
  assign sum_wr = stat_sum_wr_i.en ? stat_sum_wr_i : div_sum_wr_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < M; i++) begin
        max_mem[i] <= '0;
        sum_mem[i] <= '0;
      end
      max_rd_data_o <= '0;
      sum_rd_data_o <= '0;
      stream_max_o  <= '0;
      stream_sum_o  <= '0;
    end else begin
      if (max_wr_i.en) begin
        max_mem[max_wr_i.addr[AddrW-1:0]] <= max_wr_i.data[WI-1:0];
      end
      if (sum_wr.en) begin
        sum_mem[sum_wr.addr[AddrW-1:0]] <= sum_wr.data;
      end
      if (max_rd_i.en) begin
        max_rd_data_o <= max_mem[max_rd_i.addr[AddrW-1:0]];
      end
      if (sum_rd_i.en) begin
        sum_rd_data_o <= sum_mem[sum_rd_i.addr[AddrW-1:0]];
      end
      if (stream_rd_i.en) begin
        stream_max_o <= max_mem[stream_rd_i.addr[AddrW-1:0]];
        stream_sum_o <= sum_mem[stream_rd_i.addr[AddrW-1:0]];
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(stat_sum_wr_i.en && div_sum_wr_i.en));

endmodule

/* logic/softmax_row_stats.sv */
// ################################################
// Softmax row statistics
// Four-stage running max and exponential sum
// ################################################

`timescale 1ns/1ns

module softmax_row_stats #(
  parameter int unsigned M            = softmax_pkg::DefM,
  parameter int unsigned N            = softmax_pkg::DefN,
  parameter int unsigned SoftmaxShift = softmax_pkg::DefSoftmaxShift
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  softmax_pkg::ctrl_t           ctrl_i,
  input  softmax_pkg::step_e           step_i,
  input  logic                         calc_en_i,
  input  softmax_pkg::score_t [N-1:0]  beat_scores_i,
  input  logic [N-1:0]                 beat_mask_i,
  input  softmax_pkg::score_t          max_rd_data_i,
  input  softmax_pkg::acc_t            sum_rd_data_i,
  output softmax_pkg::buf_rd_t         max_rd_o,
  output softmax_pkg::buf_rd_t         sum_rd_o,
  output softmax_pkg::buf_wr_t         max_wr_o,
  output softmax_pkg::buf_wr_t         sum_wr_o,
  output logic                         fifo_push_o,
  output softmax_pkg::acc_t            fifo_data_o
);
  import softmax_pkg::*;

  localparam int unsigned Beats = M * M / N;
  localparam score_t MinScore = {1'b1, {(WI-1){1'b0}}};

  cnt_t cnt_q, tile_q;
  cnt_t cnt_q1, cnt_q2, cnt_q3;
  cnt_t tile_q1, tile_q2, tile_q3;
  logic en_q1, en_q2, en_q3;
  logic beat, prev0, prev_q1, prev_q2, last_q3;

  score_t [N-1:0]        scores_q1;
  logic [N-1:0]          mask_q1;
  score_t                max_new, max_q2;
  logic [N-1:0]          keep, keep_q2;
  logic [N-1:0][WI-1:0]  lane_shift, shift_q2;
  logic [WI-1:0]         sum_shift, sum_shift_q2;
  acc_t                  exp_sum, sum_q3;

  function automatic cnt_t row_addr(cnt_t c);
    return cnt_t'(c % M);
  endfunction

  assign beat    = calc_en_i && (step_i == StepQk);
  // A row has earlier state unless this is its very first beat
  assign prev0   = (tile_q != '0) || (cnt_q >= M);
  assign prev_q1 = (tile_q1 != '0) || (cnt_q1 >= M);
  assign prev_q2 = (tile_q2 != '0) || (cnt_q2 >= M);
  assign last_q3 = (tile_q3 == cnt_t'(ctrl_i.tile_s - 1)) && (cnt_q3 >= Beats - M);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q   <= '0;
      tile_q  <= '0;
      en_q1   <= 1'b0;
      en_q2   <= 1'b0;
      en_q3   <= 1'b0;
      cnt_q1  <= '0;
      cnt_q2  <= '0;
      cnt_q3  <= '0;
      tile_q1 <= '0;
      tile_q2 <= '0;
      tile_q3 <= '0;
    end else begin
      if (step_i != StepQk) begin
        cnt_q  <= '0;
        tile_q <= '0;
      end else if (calc_en_i) begin
        if (cnt_q == cnt_t'(Beats - 1)) begin
          cnt_q  <= '0;
          tile_q <= (tile_q == cnt_t'(ctrl_i.tile_s - 1)) ? '0 : tile_q + 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
      en_q1   <= beat;
      en_q2   <= en_q1;
      en_q3   <= en_q2;
      cnt_q1  <= cnt_q;
      cnt_q2  <= cnt_q1;
      cnt_q3  <= cnt_q2;
      tile_q1 <= tile_q;
      tile_q2 <= tile_q1;
      tile_q3 <= tile_q2;
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat) begin
      scores_q1 <= beat_scores_i;
      mask_q1   <= beat_mask_i;
    end
    if (en_q1) begin
      max_q2       <= max_new;
      keep_q2      <= keep;
      shift_q2     <= lane_shift;
      sum_shift_q2 <= sum_shift;
    end
    if (en_q2) begin
      sum_q3 <= exp_sum;
    end
  end

  // Stage 1 lane masking, new max and shift amounts
  always_comb begin
    int unsigned col;
    logic [WI-1:0] diff;
    max_new = prev_q1 ? max_rd_data_i : MinScore;
    for (int i = 0; i < N; i++) begin
      col     = tile_q1 * M + N * (cnt_q1 / M) + i;
      keep[i] = (col < ctrl_i.seq_length) && !mask_q1[i];
      if (keep[i] && (scores_q1[i] > max_new)) begin
        max_new = scores_q1[i];
      end
    end
    for (int i = 0; i < N; i++) begin
      diff          = max_new - scores_q1[i];
      lane_shift[i] = round_shift(diff, SoftmaxShift);
    end
    diff      = max_new - max_rd_data_i;
    sum_shift = prev_q1 ? round_shift(diff, SoftmaxShift) : '0;
  end

  // Stage 2 rescales the old sum to the new max
  always_comb begin
    exp_sum = prev_q2 ? (sum_rd_data_i >> sum_shift_q2) : '0;
    for (int i = 0; i < N; i++) begin
      if (keep_q2[i]) begin
        exp_sum = exp_sum + (acc_t'(ExpOne) >> shift_q2[i]);
      end
    end
  end

  assign max_rd_o    = '{en: beat && prev0, addr: row_addr(cnt_q)};
  assign sum_rd_o    = '{en: en_q1 && prev_q1, addr: row_addr(cnt_q1)};
  assign max_wr_o    = '{en: en_q2, addr: row_addr(cnt_q2), data: acc_t'(max_q2)};
  assign sum_wr_o    = '{en: en_q3 && !last_q3, addr: row_addr(cnt_q3), data: sum_q3};
  assign fifo_push_o = en_q3 && last_q3;
  assign fifo_data_o = sum_q3;

  // A pass never runs past its last column tile
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (step_i == StepQk) |-> (tile_q < ctrl_i.tile_s));

endmodule

/* logic/softmax_serial_div.sv */
// ################################################
// Softmax serial divider
// Restoring divide of the reciprocal constant
// ################################################

`timescale 1ns/1ns

module softmax_serial_div (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              valid_i,
  input  softmax_pkg::acc_t divisor_i,
  input  logic              ready_i,
  output logic              ready_o,
  output logic              valid_o,
  output softmax_pkg::acc_t quotient_o
);
  import softmax_pkg::*;

  localparam int unsigned BitW = $clog2(AccWidth);

  div_state_e      state_q;
  logic [BitW-1:0] bit_q;
  acc_t            divisor_q, quot_q, rem_q;
  logic [AccWidth:0] trial;

  assign ready_o    = (state_q == DivIdle);
  assign valid_o    = (state_q == DivDone);
  assign quotient_o = quot_q;
  // Next dividend bit shifts from the top of the quotient register
  assign trial      = {rem_q, quot_q[AccWidth-1]};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DivIdle;
      bit_q   <= '0;
    end else begin
      case (state_q)
        DivIdle: begin
          if (valid_i) begin
            state_q <= DivBusy;
            bit_q   <= '0;
          end
        end
        DivBusy: begin
          bit_q <= bit_q + 1'b1;
          if (bit_q == BitW'(AccWidth - 1)) begin
            state_q <= DivDone;
          end
        end
        DivDone: begin
          if (ready_i) begin
            state_q <= DivIdle;
          end
        end
        default: state_q <= DivIdle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      divisor_q <= divisor_i;
      quot_q    <= acc_t'(ReciprocalNum);
      rem_q     <= '0;
    end else if (state_q == DivBusy) begin
      if (trial >= {1'b0, divisor_q}) begin
        rem_q  <= acc_t'(trial - {1'b0, divisor_q});
        quot_q <= {quot_q[AccWidth-2:0], 1'b1};
      end else begin
        rem_q  <= trial[AccWidth-1:0];
        quot_q <= {quot_q[AccWidth-2:0], 1'b0};
      end
    end
  end

endmodule

/* logic/softmax_stream.sv */
// ################################################
// Softmax stream stage
// Normalizes one score row per request
// ################################################

`timescale 1ns/1ns

module softmax_stream #(
  parameter int unsigned M            = softmax_pkg::DefM,
  parameter int unsigned SoftmaxShift = softmax_pkg::DefSoftmaxShift
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  softmax_pkg::ctrl_t                 ctrl_i,
  input  logic                               stream_en_i,
  input  softmax_pkg::score_t [M-1:0]        stream_scores_i,
  input  softmax_pkg::cnt_t                  stream_inner_tile_i,
  input  softmax_pkg::cnt_t                  stream_tile_y_i,
  input  softmax_pkg::score_t                max_i,
  input  softmax_pkg::acc_t                  sum_i,
  output softmax_pkg::buf_rd_t               rd_o,
  output logic [M-1:0][softmax_pkg::WI-1:0]  stream_o,
  output logic                               stream_valid_o
);
  import softmax_pkg::*;

  cnt_t           row_q, row_s_q, inner_q, tile_y_q;
  score_t [M-1:0] scores_q;
  logic           valid_q, row_off;

  assign rd_o           = '{en: stream_en_i, addr: row_q};
  assign stream_valid_o = valid_q;
  assign row_off        = (tile_y_q * M + row_s_q) >= ctrl_i.seq_length;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= stream_en_i;
      if (stream_en_i) begin
        row_q <= (row_q == cnt_t'(M - 1)) ? '0 : row_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (stream_en_i) begin
      row_s_q  <= row_q;
      scores_q <= stream_scores_i;
      inner_q  <= stream_inner_tile_i;
      tile_y_q <= stream_tile_y_i;
    end
  end

  for (genvar i = 0; i < M; i++) begin : g_lane
    logic [WI-1:0] sh;
    acc_t          scaled;
    logic          col_off;

    assign col_off = (inner_q * M + i) >= ctrl_i.seq_length;
    assign sh      = round_shift(max_i - scores_q[i], SoftmaxShift);
    assign scaled  = sum_i >> sh;
    // Saturate to the 8-bit output range
    assign stream_o[i] = (!valid_q || row_off || col_off) ? '0 :
                         (|scaled[AccWidth-1:WI]) ? '1 : scaled[WI-1:0];
  end

endmodule

/* logic/softmax_top.sv */
// ################################################
// Softmax unit top level
// ################################################

`timescale 1ns/1ns

module softmax_top #(
  parameter int unsigned M            = softmax_pkg::DefM,
  parameter int unsigned N            = softmax_pkg::DefN,
  parameter int unsigned NumDiv       = softmax_pkg::DefNumDiv,
  parameter int unsigned SoftmaxShift = softmax_pkg::DefSoftmaxShift
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  softmax_pkg::ctrl_t                 ctrl_i,
  input  softmax_pkg::step_e                 step_i,
  input  logic                               calc_en_i,
  input  softmax_pkg::score_t [N-1:0]        beat_scores_i,
  input  logic [N-1:0]                       beat_mask_i,
  input  logic                               stream_en_i,
  input  softmax_pkg::score_t [M-1:0]        stream_scores_i,
  input  softmax_pkg::cnt_t                  stream_inner_tile_i,
  input  softmax_pkg::cnt_t                  stream_tile_y_i,
  output logic [M-1:0][softmax_pkg::WI-1:0]  stream_o,
  output logic                               stream_valid_o,
  output logic                               softmax_done_o
);
  import softmax_pkg::*;

  buf_rd_t max_rd, sum_rd, stream_rd;
  buf_wr_t max_wr, stat_sum_wr, div_sum_wr;
  score_t  max_rd_data, stream_max;
  acc_t    sum_rd_data, stream_sum, fifo_data;
  logic    fifo_push;

  softmax_row_stats #(
    .M            (M),
    .N            (N),
    .SoftmaxShift (SoftmaxShift)
  ) u_row_stats (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ctrl_i        (ctrl_i),
    .step_i        (step_i),
    .calc_en_i     (calc_en_i),
    .beat_scores_i (beat_scores_i),
    .beat_mask_i   (beat_mask_i),
    .max_rd_data_i (max_rd_data),
    .sum_rd_data_i (sum_rd_data),
    .max_rd_o      (max_rd),
    .sum_rd_o      (sum_rd),
    .max_wr_o      (max_wr),
    .sum_wr_o      (stat_sum_wr),
    .fifo_push_o   (fifo_push),
    .fifo_data_o   (fifo_data)
  );

  softmax_row_buffers #(
    .M (M)
  ) u_row_buffers (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .max_rd_i      (max_rd),
    .max_wr_i      (max_wr),
    .sum_rd_i      (sum_rd),
    .stream_rd_i   (stream_rd),
    .stat_sum_wr_i (stat_sum_wr),
    .div_sum_wr_i  (div_sum_wr),
    .max_rd_data_o (max_rd_data),
    .sum_rd_data_o (sum_rd_data),
    .stream_max_o  (stream_max),
    .stream_sum_o  (stream_sum)
  );

  softmax_div_dispatch #(
    .M      (M),
    .NumDiv (NumDiv)
  ) u_div_dispatch (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (fifo_push),
    .push_data_i (fifo_data),
    .sum_wr_o    (div_sum_wr),
    .done_o      (softmax_done_o)
  );

  softmax_stream #(
    .M            (M),
    .SoftmaxShift (SoftmaxShift)
  ) u_stream (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .ctrl_i              (ctrl_i),
    .stream_en_i         (stream_en_i),
    .stream_scores_i     (stream_scores_i),
    .stream_inner_tile_i (stream_inner_tile_i),
    .stream_tile_y_i     (stream_tile_y_i),
    .max_i               (stream_max),
    .sum_i               (stream_sum),
    .rd_o                (stream_rd),
    .stream_o            (stream_o),
    .stream_valid_o      (stream_valid_o)
  );

endmodule

/* src.f */
logic/softmax_pkg.sv
logic/softmax_serial_div.sv
logic/softmax_row_stats.sv
logic/softmax_div_dispatch.sv
logic/softmax_row_buffers.sv
logic/softmax_stream.sv
logic/softmax_top.sv
bench/softmax_checker.sv
bench/softmax_tb.sv
